//--- source/cpu_pkg.sv
package cpu_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and memory sizes
	////////////////////////////////////////////////////////////////////////////
	localparam int xlen       = 32;
	localparam int imem_depth = 256;
	localparam int dmem_depth = 256;
	localparam int mem_addr_w = 8;

	// Major opcodes, bits 31:27 of every instruction
	localparam logic [4:0] op_alu  = 5'b00000;
	localparam logic [4:0] op_j    = 5'b00001;
	localparam logic [4:0] op_bne  = 5'b00010;
	localparam logic [4:0] op_jal  = 5'b00011;
	localparam logic [4:0] op_jr   = 5'b00100;
	localparam logic [4:0] op_addi = 5'b00101;
	localparam logic [4:0] op_blt  = 5'b00110;
	localparam logic [4:0] op_sw   = 5'b00111;
	localparam logic [4:0] op_lw   = 5'b01000;

	// ALU function codes, aluop field of R-type
	localparam logic [4:0] alu_add = 5'b00000;
	localparam logic [4:0] alu_sub = 5'b00001;
	localparam logic [4:0] alu_and = 5'b00010;
	localparam logic [4:0] alu_or  = 5'b00011;
	localparam logic [4:0] alu_sll = 5'b00100;
	localparam logic [4:0] alu_sra = 5'b00101;

	typedef struct packed {
		logic [4:0] opcode;
		logic [4:0] rd;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] shamt;
		logic [4:0] aluop;
		logic [1:0] spare;
	} r_fmt_t;

	// Jump target is {rd, rs, imm} of this view
	typedef struct packed {
		logic [4:0]         opcode;
		logic [4:0]         rd;
		logic [4:0]         rs;
		logic signed [16:0] imm;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_t;

	// APB register map
	localparam logic [11:0] reg_ctrl      = 12'h000;
	localparam logic [11:0] reg_imem_addr = 12'h004;
	localparam logic [11:0] reg_imem_data = 12'h008;
	localparam logic [11:0] dmem_win_lo   = 12'h400;
	localparam logic [11:0] dmem_win_hi   = 12'h7FC;

	// Operand bypass selects
	typedef logic [1:0] sel_t;
	localparam sel_t byp_none = 2'd0;
	localparam sel_t byp_em   = 2'd1;
	localparam sel_t byp_mw   = 2'd2;
	localparam sel_t byp_alu  = 2'd3;

endpackage

//--- source/alu.sv
`timescale 1ns/1ns

module alu import cpu_pkg::*; (
	input  logic [xlen-1:0] a,
	input  logic [xlen-1:0] b,
	input  logic [4:0]      op,
	input  logic [4:0]      shamt,
	output logic [xlen-1:0] result,
	output logic            not_equal,
	output logic            less_than
);

	logic [xlen-1:0] diff;

	assign diff = a - b;

	// Signed compare where differing sign bits decide
	assign not_equal = |diff;
	assign less_than = (a[xlen-1] ^ b[xlen-1]) ? a[xlen-1] : diff[xlen-1];

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = diff;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_sll: result = a << shamt;
			// Arithmetic shift keeps the sign of a
			alu_sra: result = $signed(a) >>> shamt;
			default: result = a + b;
		endcase
	end

endmodule

//--- source/regfile.sv
`timescale 1ns/1ns

module regfile import cpu_pkg::*; (
	input  logic            clock,
	input  logic            rst_n,
	input  logic            we,
	input  logic [4:0]      waddr,
	input  logic [xlen-1:0] wdata,
	input  logic [4:0]      raddr_a,
	input  logic [4:0]      raddr_b,
	output logic [xlen-1:0] rdata_a,
	output logic [xlen-1:0] rdata_b
);

	logic [xlen-1:0] regs [32];
	logic            wr_ok;

	assign wr_ok = we && (waddr != 5'd0);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_ok) begin
			regs[waddr] <= wdata;
		end
	end

	// Same-cycle write shows up on the read ports
	assign rdata_a = (raddr_a == 5'd0) ? '0 :
		(wr_ok && waddr == raddr_a) ? wdata : regs[raddr_a];
	assign rdata_b = (raddr_b == 5'd0) ? '0 :
		(wr_ok && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule

//--- source/decode_ctrl.sv
`timescale 1ns/1ns

module decode_ctrl import cpu_pkg::*; (
	input  instr_t          instr,
	output logic [4:0]      rs_sel,
	output logic [4:0]      rt_sel,
	output logic [4:0]      rd_sel,
	output logic [xlen-1:0] imm,
	output logic [4:0]      alu_op,
	output logic [4:0]      shamt,
	output logic            use_imm,
	output logic            reg_we,
	output logic            is_load,
	output logic            is_store,
	output logic            is_branch_ne,
	output logic            is_branch_lt,
	output logic            is_jump,
	output logic            is_link,
	output logic            is_jr
);

	assign imm   = {{(xlen-17){instr.i.imm[16]}}, instr.i.imm};
	assign shamt = instr.r.shamt;

	always_comb begin
		rs_sel       = 5'd0;
		rt_sel       = 5'd0;
		rd_sel       = 5'd0;
		alu_op       = alu_add;
		use_imm      = 1'b0;
		reg_we       = 1'b0;
		is_load      = 1'b0;
		is_store     = 1'b0;
		is_branch_ne = 1'b0;
		is_branch_lt = 1'b0;
		is_jump      = 1'b0;
		is_link      = 1'b0;
		is_jr        = 1'b0;
		case (instr.r.opcode)
			op_alu: begin
				rs_sel = instr.r.rs;
				rt_sel = instr.r.rt;
				rd_sel = instr.r.rd;
				alu_op = instr.r.aluop;
				reg_we = 1'b1;
			end
			op_addi, op_lw: begin
				rs_sel  = instr.i.rs;
				rd_sel  = instr.i.rd;
				use_imm = 1'b1;
				reg_we  = 1'b1;
				is_load = (instr.i.opcode == op_lw);
			end
			// Base in rs, store data in rd
			op_sw: begin
				rs_sel   = instr.i.rs;
				rt_sel   = instr.i.rd;
				use_imm  = 1'b1;
				is_store = 1'b1;
			end
			op_bne, op_blt: begin
				rs_sel       = instr.i.rd;
				rt_sel       = instr.i.rs;
				alu_op       = alu_sub;
				is_branch_ne = (instr.i.opcode == op_bne);
				is_branch_lt = (instr.i.opcode == op_blt);
			end
			op_j: is_jump = 1'b1;
			op_jal: begin
				rd_sel  = 5'd31;
				reg_we  = 1'b1;
				is_jump = 1'b1;
				is_link = 1'b1;
			end
			op_jr: begin
				rt_sel  = instr.i.rd;
				is_jump = 1'b1;
				is_jr   = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

//--- source/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit import cpu_pkg::*; (
	input  logic [4:0] fd_rs,
	input  logic [4:0] fd_rt,
	input  logic       fd_store,
	input  logic [4:0] de_rs,
	input  logic [4:0] de_rt,
	input  logic [4:0] de_rd,
	input  logic       de_we,
	input  logic       de_load,
	input  logic [4:0] em_rt,
	input  logic [4:0] em_rd,
	input  logic       em_we,
	input  logic       em_load,
	input  logic       em_store,
	input  logic [4:0] mw_rd,
	input  logic       mw_we,
	output sel_t       byp_ex_a,
	output sel_t       byp_ex_b,
	output sel_t       byp_dec_a,
	output sel_t       byp_dec_b,
	output logic       byp_store,
	output logic       stall
);

	// Execute operands, skipping a load still in em
	function automatic sel_t pick_ex(input logic [4:0] src);
		if (src == 5'd0)
			return byp_none;
		if (em_we && em_rd == src)
			return em_load ? byp_none : byp_em;
		if (mw_we && mw_rd == src)
			return byp_mw;
		return byp_none;
	endfunction

	// Decode operands with the execute result as youngest source
	function automatic sel_t pick_dec(input logic [4:0] src);
		if (src == 5'd0)
			return byp_none;
		if (de_we && de_rd == src)
			return de_load ? byp_none : byp_alu;
		if (em_we && em_rd == src)
			return byp_em;
		if (mw_we && mw_rd == src)
			return byp_mw;
		return byp_none;
	endfunction

	assign byp_ex_a  = pick_ex(de_rs);
	assign byp_ex_b  = pick_ex(de_rt);
	assign byp_dec_a = pick_dec(fd_rs);
	assign byp_dec_b = pick_dec(fd_rt);

	// Load right before a store of the same register is fixed in memory stage
	assign byp_store = em_store && mw_we && (em_rt != 5'd0) && (mw_rd == em_rt);

	assign stall = de_load && (de_rd != 5'd0) &&
		((de_rd == fd_rs) || (de_rd == fd_rt && !fd_store));

endmodule

//--- source/cpu_pipeline.sv
`timescale 1ns/1ns

module cpu_pipeline import cpu_pkg::*; (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  run,
	input  logic                  imem_we,
	input  logic [mem_addr_w-1:0] imem_waddr,
	input  logic [xlen-1:0]       imem_wdata,
	input  logic [mem_addr_w-1:0] dbg_addr,
	output logic [xlen-1:0]       dbg_rdata,
	output logic                  lcd_write,
	output logic [xlen-1:0]       lcd_data
);

	logic [xlen-1:0] imem [imem_depth];
	logic [xlen-1:0] dmem [dmem_depth];

	logic            flush, stall, ex_jump, br_go;
	logic [xlen-1:0] pc, pc1, br_target, jump_target;
	instr_t          fd_ir, de_ir, em_ir;
	logic [xlen-1:0] fd_pc1, de_pc1, de_a, de_b, em_pc1, em_alu, em_b;
	logic [xlen-1:0] mw_pc1, mw_alu, mw_ld;
	logic            mw_we, mw_load, mw_link;
	logic [4:0]      mw_rd;

	logic [4:0]      fd_rs, fd_rt, de_rs, de_rt, de_rd, em_rt, em_rd, de_alu_op, de_shamt;
	logic [xlen-1:0] fd_imm, de_imm;
	logic            fd_bne, fd_blt, fd_store, br_ne, br_lt;
	logic            de_use_imm, de_we, de_load, de_jump, de_link, de_jr;
	logic            em_we, em_load, em_store, em_link;
	sel_t            byp_ex_a, byp_ex_b, byp_dec_a, byp_dec_b;
	logic            byp_store;

	logic [xlen-1:0] rf_a, rf_b, dec_a, dec_b, ex_a, ex_b, alu_b, alu_out;
	logic [xlen-1:0] ex_val, em_val, dmem_rdata, store_data, wb_data;

	// Holding run low restarts the program from address 0
	assign flush = !rst_n || !run;

	////////////////////////////////////////////////////////////////////////////
	// Fetch
	////////////////////////////////////////////////////////////////////////////
	assign pc1 = pc + 32'd1;

	always_ff @(posedge clock) begin
		if (imem_we)
			imem[imem_waddr] <= imem_wdata;
	end

	// Jump in execute beats a branch in decode
	always_ff @(posedge clock) begin
		if (flush) begin
			pc    <= '0;
			fd_ir <= '0;
		end else if (ex_jump) begin
			pc    <= jump_target;
			fd_ir <= '0;
		end else if (!stall) begin
			pc    <= br_go ? br_target : pc1;
			fd_ir <= br_go ? '0 : imem[pc[mem_addr_w-1:0]];
		end
	end

	always_ff @(posedge clock) begin
		if (!stall)
			fd_pc1 <= pc1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Decode and branch resolve
	////////////////////////////////////////////////////////////////////////////
	decode_ctrl dec_fd (
		.instr(fd_ir), .rs_sel(fd_rs), .rt_sel(fd_rt), .rd_sel(), .imm(fd_imm),
		.alu_op(), .shamt(), .use_imm(), .reg_we(), .is_load(), .is_store(fd_store),
		.is_branch_ne(fd_bne), .is_branch_lt(fd_blt), .is_jump(), .is_link(), .is_jr()
	);

	regfile rf (
		.clock(clock), .rst_n(rst_n), .we(mw_we), .waddr(mw_rd), .wdata(wb_data),
		.raddr_a(fd_rs), .raddr_b(fd_rt), .rdata_a(rf_a), .rdata_b(rf_b)
	);

	always_comb begin
		case (byp_dec_a)
			byp_alu: dec_a = ex_val;
			byp_em:  dec_a = em_val;
			byp_mw:  dec_a = wb_data;
			default: dec_a = rf_a;
		endcase
		case (byp_dec_b)
			byp_alu: dec_b = ex_val;
			byp_em:  dec_b = em_val;
			byp_mw:  dec_b = wb_data;
			default: dec_b = rf_b;
		endcase
	end

	// Second ALU used only as the branch comparator
	alu br_cmp (
		.a(dec_a), .b(dec_b), .op(alu_sub), .shamt(5'd0),
		.result(), .not_equal(br_ne), .less_than(br_lt)
	);

	assign br_target = fd_pc1 + fd_imm;
	assign br_go = ((fd_bne && br_ne) || (fd_blt && br_lt)) && !stall && !ex_jump;

	always_ff @(posedge clock) begin
		if (flush || ex_jump || stall)
			de_ir <= '0;
		else
			de_ir <= fd_ir;
	end

	always_ff @(posedge clock) begin
		de_pc1 <= fd_pc1;
		de_a   <= dec_a;
		de_b   <= dec_b;
	end

	////////////////////////////////////////////////////////////////////////////
	// Execute and jump resolve
	////////////////////////////////////////////////////////////////////////////
	decode_ctrl dec_de (
		.instr(de_ir), .rs_sel(de_rs), .rt_sel(de_rt), .rd_sel(de_rd), .imm(de_imm),
		.alu_op(de_alu_op), .shamt(de_shamt), .use_imm(de_use_imm), .reg_we(de_we),
		.is_load(de_load), .is_store(), .is_branch_ne(), .is_branch_lt(),
		.is_jump(de_jump), .is_link(de_link), .is_jr(de_jr)
	);

	assign ex_a = (byp_ex_a == byp_em) ? em_val : (byp_ex_a == byp_mw) ? wb_data : de_a;
	assign ex_b = (byp_ex_b == byp_em) ? em_val : (byp_ex_b == byp_mw) ? wb_data : de_b;
	assign alu_b = de_use_imm ? de_imm : ex_b;

	alu ex_alu (
		.a(ex_a), .b(alu_b), .op(de_alu_op), .shamt(de_shamt),
		.result(alu_out), .not_equal(), .less_than()
	);

	assign ex_val  = de_link ? de_pc1 : alu_out;
	assign ex_jump = de_jump;
	assign jump_target = de_jr ? ex_b :
		{{(xlen-27){1'b0}}, de_ir.i.rd, de_ir.i.rs, de_ir.i.imm};

	always_ff @(posedge clock) begin
		if (flush)
			em_ir <= '0;
		else
			em_ir <= de_ir;
	end

	always_ff @(posedge clock) begin
		em_pc1 <= de_pc1;
		em_alu <= alu_out;
		em_b   <= ex_b;
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory
	////////////////////////////////////////////////////////////////////////////
	decode_ctrl dec_em (
		.instr(em_ir), .rs_sel(), .rt_sel(em_rt), .rd_sel(em_rd), .imm(), .alu_op(),
		.shamt(), .use_imm(), .reg_we(em_we), .is_load(em_load), .is_store(em_store),
		.is_branch_ne(), .is_branch_lt(), .is_jump(), .is_link(em_link), .is_jr()
	);

	assign dmem_rdata = dmem[em_alu[mem_addr_w-1:0]];
	assign store_data = byp_store ? wb_data : em_b;
	assign em_val     = em_load ? dmem_rdata : (em_link ? em_pc1 : em_alu);
	assign dbg_rdata  = dmem[dbg_addr];

	always_ff @(posedge clock) begin
		if (em_store)
			dmem[em_alu[mem_addr_w-1:0]] <= store_data;
	end

	always_ff @(posedge clock) begin
		if (flush) begin
			mw_we   <= 1'b0;
			mw_load <= 1'b0;
			mw_link <= 1'b0;
			mw_rd   <= 5'd0;
		end else begin
			mw_we   <= em_we;
			mw_load <= em_load;
			mw_link <= em_link;
			mw_rd   <= em_rd;
		end
	end

	always_ff @(posedge clock) begin
		mw_pc1 <= em_pc1;
		mw_alu <= em_alu;
		mw_ld  <= dmem_rdata;
	end

	// Writeback source select
	assign wb_data   = mw_load ? mw_ld : (mw_link ? mw_pc1 : mw_alu);
	assign lcd_write = mw_load;
	assign lcd_data  = wb_data;

	hazard_unit hz (
		.fd_rs(fd_rs), .fd_rt(fd_rt), .fd_store(fd_store),
		.de_rs(de_rs), .de_rt(de_rt), .de_rd(de_rd), .de_we(de_we), .de_load(de_load),
		.em_rt(em_rt), .em_rd(em_rd), .em_we(em_we), .em_load(em_load),
		.em_store(em_store), .mw_rd(mw_rd), .mw_we(mw_we),
		.byp_ex_a(byp_ex_a), .byp_ex_b(byp_ex_b), .byp_dec_a(byp_dec_a),
		.byp_dec_b(byp_dec_b), .byp_store(byp_store), .stall(stall)
	);

endmodule

//--- source/cpu_apb_regs.sv
`timescale 1ns/1ns

module cpu_apb_regs import cpu_pkg::*; (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [11:0]           paddr,
	input  logic [xlen-1:0]       pwdata,
	input  logic [xlen-1:0]       dbg_rdata,
	output logic [xlen-1:0]       prdata,
	output logic                  pready,
	output logic                  pslverr,
	output logic                  run,
	output logic                  imem_we,
	output logic [mem_addr_w-1:0] imem_waddr,
	output logic [xlen-1:0]       imem_wdata,
	output logic [mem_addr_w-1:0] dbg_addr
);

	logic                  access, wr, rd;
	logic                  hit_ctrl, hit_iaddr, hit_idata, hit_win;
	logic [mem_addr_w-1:0] load_addr;

	assign access = psel && penable;
	assign wr     = access && pwrite;
	assign rd     = access && !pwrite;

	assign hit_ctrl  = (paddr == reg_ctrl);
	assign hit_iaddr = (paddr == reg_imem_addr);
	assign hit_idata = (paddr == reg_imem_data);
	assign hit_win   = (paddr >= dmem_win_lo) && (paddr <= dmem_win_hi);

	// No wait states
	assign pready = 1'b1;

	// Memory ports only open while the core is held
	assign pslverr = access && (!(hit_ctrl || hit_iaddr || hit_idata || hit_win) ||
		(wr && run && (hit_iaddr || hit_idata)) || (rd && run && hit_win));

	assign imem_we    = wr && hit_idata && !run;
	assign imem_waddr = load_addr;
	assign imem_wdata = pwdata;
	assign dbg_addr   = paddr[mem_addr_w+1:2];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			run       <= 1'b0;
			load_addr <= '0;
		end else begin
			if (wr && hit_ctrl)
				run <= pwdata[0];
			if (wr && hit_iaddr && !run)
				load_addr <= pwdata[mem_addr_w-1:0];
			else if (imem_we)
				load_addr <= load_addr + 1'b1;
		end
	end

	always_comb begin
		prdata = '0;
		if (hit_ctrl)
			prdata = {{(xlen-1){1'b0}}, run};
		else if (hit_iaddr)
			prdata = {{(xlen-mem_addr_w){1'b0}}, load_addr};
		else if (hit_win)
			prdata = dbg_rdata;
	end

endmodule

//--- source/cpu_top.sv
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [11:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        lcd_write,
	output logic [31:0] lcd_data
);

	logic                  run, imem_we;
	logic [mem_addr_w-1:0] imem_waddr, dbg_addr;
	logic [xlen-1:0]       imem_wdata, dbg_rdata;

	cpu_apb_regs regs (
		.clock(clock), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .dbg_rdata(dbg_rdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .run(run), .imem_we(imem_we),
		.imem_waddr(imem_waddr), .imem_wdata(imem_wdata), .dbg_addr(dbg_addr)
	);

	cpu_pipeline pipe (
		.clock(clock), .rst_n(rst_n), .run(run), .imem_we(imem_we),
		.imem_waddr(imem_waddr), .imem_wdata(imem_wdata), .dbg_addr(dbg_addr),
		.dbg_rdata(dbg_rdata), .lcd_write(lcd_write), .lcd_data(lcd_data)
	);

endmodule

//--- verification/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb import cpu_pkg::*; ();

	logic        clock, rst_n;
	logic        psel, penable, pwrite;
	logic [11:0] paddr;
	logic [31:0] pwdata, prdata, lcd_data;
	logic        pready, pslverr, lcd_write;

	logic [31:0] prog [$];
	logic [31:0] lfsr;

	cpu_top uut (
		.clock(clock), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .lcd_write(lcd_write), .lcd_data(lcd_data)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reporting and reference helpers
	////////////////////////////////////////////////////////////////////////////
	task automatic abort_run(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp));
	endtask

	// 32-bit Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int k = 0; k < n; k++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [31:0] sext17(input logic [31:0] v);
		return {{15{v[16]}}, v[16:0]};
	endfunction

	function automatic logic [31:0] model_alu(input logic [4:0] op, input logic [31:0] a,
		input logic [31:0] b, input logic [4:0] sh);
		logic [31:0] r;
		case (op)
			alu_add: r = a + b;
			alu_sub: r = a - b;
			alu_and: r = a & b;
			alu_or:  r = a | b;
			alu_sll: r = a << sh;
			default: begin
				// Shift one place at a time while copying the sign bit in
				r = a;
				for (int k = 0; k < sh; k++)
					r = {r[31], r[31:1]};
			end
		endcase
		return r;
	endfunction

	// Instruction encoders
	function automatic logic [31:0] r_word(input logic [4:0] aluop, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sh);
		return {op_alu, rd, rs, rt, sh, aluop, 2'b00};
	endfunction

	function automatic logic [31:0] i_word(input logic [4:0] op, input logic [4:0] rd,
		input logic [4:0] rs, input logic [31:0] imm);
		return {op, rd, rs, imm[16:0]};
	endfunction

	function automatic logic [31:0] j_word(input logic [4:0] op, input logic [31:0] target);
		return {op, target[26:0]};
	endfunction

	// Jump to itself to park the core after the last instruction
	task automatic push_halt();
		prog.push_back(j_word(op_j, 32'(prog.size())));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// APB access
	////////////////////////////////////////////////////////////////////////////
	task automatic wait_ready();
		int n;
		n = 0;
		@(negedge clock);
		while (!pready) begin
			if (n == 20) begin
				abort_run("APB slave never raised pready");
			end else begin
				n++;
				@(negedge clock);
			end
		end
	endtask

	task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge clock);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clock);
		#1;
		penable = 1'b1;
		wait_ready();
		rdata = prdata;
		err   = pslverr;
		@(posedge clock);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] rd_ignored;
		apb_xfer(1'b1, addr, data, rd_ignored, err);
	endtask

	task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
		apb_xfer(1'b0, addr, 32'd0, data, err);
	endtask

	task automatic write_ok(input logic [11:0] addr, input logic [31:0] data);
		logic err;
		apb_write(addr, data, err);
		check("pslverr", {31'd0, err}, 32'd0);
	endtask

	task automatic read_expect(input string name, input logic [11:0] addr,
		input logic [31:0] exp);
		logic [31:0] d;
		logic        err;
		apb_read(addr, d, err);
		check("pslverr", {31'd0, err}, 32'd0);
		check(name, d, exp);
	endtask

	task automatic expect_slverr(input logic wr, input logic [11:0] addr);
		logic [31:0] d;
		logic        err;
		apb_xfer(wr, addr, 32'h0, d, err);
		check("pslverr", {31'd0, err}, 32'd1);
	endtask

	task automatic check_dmem(input int w, input logic [31:0] exp);
		read_expect($sformatf("dmem[%0d]", w), dmem_win_lo + 12'(4 * w), exp);
	endtask

	task automatic load_program();
		write_ok(reg_imem_addr, 32'd0);
		foreach (prog[k])
			write_ok(reg_imem_data, prog[k]);
		read_expect("imem_addr", reg_imem_addr, 32'(prog.size()));
	endtask

	task automatic run_for(input int cycles);
		write_ok(reg_ctrl, 32'd1);
		repeat (cycles) @(posedge clock);
		write_ok(reg_ctrl, 32'd0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////
	task automatic register_block();
		check("pslverr", {31'd0, pslverr}, 32'd0);
		check("lcd_write", {31'd0, lcd_write}, 32'd0);
		read_expect("ctrl", reg_ctrl, 32'd0);
		write_ok(reg_imem_addr, 32'h5);
		read_expect("imem_addr", reg_imem_addr, 32'h5);
		expect_slverr(1'b0, 12'h00C);
		expect_slverr(1'b1, 12'h800);
		prog.delete();
		push_halt();
		load_program();
		write_ok(reg_ctrl, 32'd1);
		read_expect("ctrl", reg_ctrl, 32'd1);
		// Memory ports closed while running
		expect_slverr(1'b1, reg_imem_data);
		expect_slverr(1'b1, reg_imem_addr);
		expect_slverr(1'b0, dmem_win_lo);
		read_expect("imem_addr", reg_imem_addr, 32'd1);
		write_ok(reg_ctrl, 32'd0);
		read_expect("ctrl", reg_ctrl, 32'd0);
	endtask

	task automatic alu_chain();
		logic [31:0] v [1:8];
		logic [31:0] imm1, imm2, sh1, sh2;
		imm1 = rand_bits(17);
		imm2 = rand_bits(17);
		sh1  = rand_bits(5);
		sh2  = rand_bits(5);
		v[1] = sext17(imm1);
		v[2] = v[1] + sext17(imm2);
		v[3] = model_alu(alu_add, v[1], v[2], 5'd0);
		v[4] = model_alu(alu_sub, v[3], v[1], 5'd0);
		v[5] = model_alu(alu_and, v[4], v[2], 5'd0);
		v[6] = model_alu(alu_or, v[5], v[3], 5'd0);
		v[7] = model_alu(alu_sll, v[6], 32'd0, sh1[4:0]);
		v[8] = model_alu(alu_sra, v[7], 32'd0, sh2[4:0]);
		prog.delete();
		prog.push_back(i_word(op_addi, 5'd1, 5'd0, imm1));
		prog.push_back(i_word(op_addi, 5'd2, 5'd1, imm2));
		prog.push_back(r_word(alu_add, 5'd3, 5'd1, 5'd2, 5'd0));
		prog.push_back(r_word(alu_sub, 5'd4, 5'd3, 5'd1, 5'd0));
		prog.push_back(r_word(alu_and, 5'd5, 5'd4, 5'd2, 5'd0));
		prog.push_back(r_word(alu_or, 5'd6, 5'd5, 5'd3, 5'd0));
		prog.push_back(r_word(alu_sll, 5'd7, 5'd6, 5'd0, sh1[4:0]));
		prog.push_back(r_word(alu_sra, 5'd8, 5'd7, 5'd0, sh2[4:0]));
		// r8 is stored right behind its producer
		for (int k = 8; k >= 1; k--)
			prog.push_back(i_word(op_sw, 5'(k), 5'd0, 32'(16 + k)));
		push_halt();
		load_program();
		run_for(60);
		for (int k = 1; k <= 8; k++)
			check_dmem(16 + k, v[k]);
	endtask

	task automatic load_use();
		logic [31:0] a, b;
		logic [31:0] want [2];
		int          seen, n;
		a       = 32'h1234;
		b       = 32'hFFFF_FFFB;
		want[0] = a;
		want[1] = a + b;
		prog.delete();
		prog.push_back(i_word(op_addi, 5'd1, 5'd0, a));
		prog.push_back(i_word(op_addi, 5'd2, 5'd0, b));
		prog.push_back(i_word(op_sw, 5'd1, 5'd0, 32'd40));
		prog.push_back(i_word(op_lw, 5'd3, 5'd0, 32'd40));
		prog.push_back(r_word(alu_add, 5'd4, 5'd3, 5'd2, 5'd0));
		prog.push_back(i_word(op_sw, 5'd4, 5'd0, 32'd41));
		prog.push_back(i_word(op_lw, 5'd5, 5'd0, 32'd41));
		prog.push_back(i_word(op_sw, 5'd5, 5'd0, 32'd42));
		push_halt();
		load_program();
		write_ok(reg_ctrl, 32'd1);
		seen = 0;
		n    = 0;
		while (seen < 2) begin
			if (n == 40) begin
				abort_run("Timeout waiting for the lcd_write pulses of the two loads");
			end else begin
				@(negedge clock);
				if (lcd_write) begin
					check("lcd_data", lcd_data, want[seen]);
					seen++;
				end
				n++;
			end
		end
		repeat (10) begin
			@(negedge clock);
			if (lcd_write)
				abort_run("lcd_write pulsed with no load in writeback");
		end
		write_ok(reg_ctrl, 32'd0);
		check_dmem(40, a);
		check_dmem(41, a + b);
		check_dmem(42, a + b);
	endtask

	task automatic control_flow();
		logic [31:0] mark;
		logic [31:0] want [50:59];
		mark = 32'h1A5;
		for (int k = 50; k <= 59; k++)
			want[k] = 32'd0;
		want[51] = mark;
		want[53] = mark;
		want[55] = mark;
		want[59] = 32'd27;
		prog.delete();
		prog.push_back(i_word(op_addi, 5'd1, 5'd0, 32'd5));
		prog.push_back(i_word(op_addi, 5'd2, 5'd0, 32'd7));
		prog.push_back(i_word(op_addi, 5'd9, 5'd0, mark));
		prog.push_back(i_word(op_addi, 5'd3, 5'd0, -32'sd3));
		for (int k = 50; k <= 59; k++)
			prog.push_back(i_word(op_sw, 5'd0, 5'd0, 32'(k)));
		// From address 14 each branch guards the sentinel store after it
		prog.push_back(i_word(op_bne, 5'd1, 5'd2, 32'd1));
		prog.push_back(i_word(op_sw, 5'd9, 5'd0, 32'd50));
		prog.push_back(i_word(op_bne, 5'd1, 5'd1, 32'd1));
		prog.push_back(i_word(op_sw, 5'd9, 5'd0, 32'd51));
		prog.push_back(i_word(op_blt, 5'd1, 5'd2, 32'd1));
		prog.push_back(i_word(op_sw, 5'd9, 5'd0, 32'd52));
		prog.push_back(i_word(op_blt, 5'd2, 5'd1, 32'd1));
		prog.push_back(i_word(op_sw, 5'd9, 5'd0, 32'd53));
		prog.push_back(i_word(op_blt, 5'd3, 5'd1, 32'd1));
		prog.push_back(i_word(op_sw, 5'd9, 5'd0, 32'd58));
		prog.push_back(j_word(op_j, 32'd26));
		prog.push_back(i_word(op_sw, 5'd9, 5'd0, 32'd54));
		prog.push_back(j_word(op_jal, 32'd29));
		prog.push_back(i_word(op_sw, 5'd9, 5'd0, 32'd55));
		push_halt();
		// Subroutine at 29 keeps a copy of the link register
		prog.push_back(i_word(op_sw, 5'd31, 5'd0, 32'd59));
		prog.push_back(i_word(op_jr, 5'd31, 5'd0, 32'd0));
		prog.push_back(i_word(op_sw, 5'd9, 5'd0, 32'd56));
		prog.push_back(i_word(op_sw, 5'd9, 5'd0, 32'd57));
		load_program();
		run_for(80);
		for (int k = 50; k <= 59; k++)
			check_dmem(k, want[k]);
	endtask

	task automatic restart_program();
		prog.delete();
		prog.push_back(i_word(op_addi, 5'd1, 5'd0, 32'h321));
		prog.push_back(i_word(op_sw, 5'd1, 5'd0, 32'd17));
		prog.push_back(r_word(alu_sub, 5'd2, 5'd0, 5'd1, 5'd0));
		prog.push_back(i_word(op_sw, 5'd2, 5'd0, 32'd18));
		prog.push_back(i_word(op_sw, 5'd1, 5'd0, 32'd50));
		push_halt();
		load_program();
		run_for(30);
		check_dmem(17, 32'h321);
		check_dmem(18, 32'hFFFF_FCDF);
		check_dmem(50, 32'h321);
	endtask

	initial begin
		rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = 12'h0;
		pwdata  = 32'h0;
		lfsr    = 32'hacc9;
		repeat (5) @(posedge clock);
		#1;
		rst_n = 1'b1;
		register_block();
		alu_chain();
		load_use();
		control_flow();
		restart_program();
		$display("all tests passed");
		$finish;
	end

endmodule

//--- flist.f
source/cpu_pkg.sv
source/alu.sv
source/regfile.sv
source/decode_ctrl.sv
source/hazard_unit.sv
source/cpu_pipeline.sv
source/cpu_apb_regs.sv
source/cpu_top.sv
verification/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cpu_tb \
	-f flist.f -Mdir obj_dir -o cpu_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/cpu_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

exit 0
